/* Makefile */
VERILATOR ?= verilator
TOP       := tb_alu_exec
FILELIST  := filelist.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0 \
             -Mdir $(BUILD_DIR) --top-module $(TOP)

SRCS    := $(shell grep -v '^+' $(FILELIST)) alu_settings.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuild only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# Exit status of the simulator is the test verdict
run: $(BIN) alu_trace.txt
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

/* alu_collect.sv */
`default_nettype none

`include "alu_settings.svh"

module alu_collect (
	input  logic                                   clk,
	input  logic                                   arst_n,
	input  logic [`ALU_LANES-1:0]                  done,
	input  logic [`ALU_LANES-1:0][`ALU_WIDTH-1:0]  res,
	input  logic [`ALU_LANES-1:0]                  n,
	input  logic [`ALU_LANES-1:0]                  z,
	input  logic [`ALU_LANES-1:0]                  v,
	input  logic [`ALU_LANES-1:0]                  flag_we,
	output logic                                   out_valid,
	output logic [`ALU_WIDTH-1:0]                  out_result,
	output logic                                   flag_n,
	output logic                                   flag_z,
	output logic                                   flag_v
);

	logic [`ALU_WIDTH-1:0] sel_res;
	logic                  sel_n;
	logic                  sel_z;
	logic                  sel_v;
	logic                  sel_we;

	// Lanes finish in issue order, so the one done lane is next in line
	always_comb begin
		sel_res = '0;
		sel_n   = 1'b0;
		sel_z   = 1'b0;
		sel_v   = 1'b0;
		sel_we  = 1'b0;
		for (int i = 0; i < `ALU_LANES; i++) begin
			if (done[i]) begin
				sel_res = res[i];
				sel_n   = n[i];
				sel_z   = z[i];
				sel_v   = v[i];
				sel_we  = flag_we[i];
			end
		end
	end

	////////////////////
	// Output and flags
	////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			flag_n    <= 1'b0;
			flag_z    <= 1'b0;
			flag_v    <= 1'b0;
		end else begin
			out_valid <= |done;
			// Architectural NZV, held across shifts
			if (|done && sel_we) begin
				flag_n <= sel_n;
				flag_z <= sel_z;
				flag_v <= sel_v;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (|done)
			out_result <= sel_res;
	end

	// Round-robin issue means lanes never finish together
	a_done_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(done));

endmodule

`default_nettype wire

/* alu_dispatch.sv */
`default_nettype none

`include "alu_settings.svh"

module alu_dispatch import alu_pkg::*; (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  in_valid,
	input  alu_op_e               in_op,
	input  logic [`ALU_WIDTH-1:0] in_a,
	input  logic [`ALU_WIDTH-1:0] in_b,
	output logic [`ALU_LANES-1:0] issue,
	output alu_op_e               iss_op,
	output logic [`ALU_WIDTH-1:0] iss_a,
	output logic [`ALU_WIDTH-1:0] iss_b
);

	localparam int PTR_W = $clog2(`ALU_LANES);

	logic             op_ok;
	logic             legal;
	logic [PTR_W-1:0] ptr;

	// Only defined functions go to a lane
	// NO_OP and unknown codes fall through to default
	always_comb begin
		case (in_op)
			ADD, ADDI, SUB, NAND, AND, ANDI, SRL, SLL, XOR: op_ok = 1'b1;
			default: op_ok = 1'b0;
		endcase
	end

	assign legal = in_valid & op_ok;

	////////////////////
	// Round-robin issue
	////////////////////

	// One-cycle issue pulse to the lane under the pointer
	// Pointer moves only when something was issued
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			issue <= '0;
			ptr   <= '0;
		end else begin
			issue <= '0;
			if (legal) begin
				issue[ptr] <= 1'b1;
				// Wrap after the last lane
				ptr <= (ptr == PTR_W'(`ALU_LANES - 1)) ? '0 : ptr + 1'b1;
			end
		end
	end

	// Shared operand buses, valid alongside the issue pulse
	always_ff @(posedge clk) begin
		if (legal) begin
			iss_op <= in_op;
			iss_a  <= in_a;
			iss_b  <= in_b;
		end
	end

	////////////////////
	// Checks
	////////////////////

	// Never more than one lane per cycle
	a_issue_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(issue));

	// A lane sees no new issue while it is still working on the last one
	for (genvar i = 0; i < `ALU_LANES; i++) begin : g_gap
		for (genvar k = 1; k < `ALU_BYTES; k++) begin : g_past
			a_lane_busy: assert property (@(posedge clk) disable iff (!arst_n)
				issue[i] |-> !$past(issue[i], k));
		end
	end

endmodule

`default_nettype wire

/* alu_exec.sv */
`default_nettype none

`include "alu_settings.svh"

module alu_exec import alu_pkg::*; (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  in_valid,
	input  alu_op_e               in_op,
	input  logic [`ALU_WIDTH-1:0] in_a,
	input  logic [`ALU_WIDTH-1:0] in_b,
	output logic                  out_valid,
	output logic [`ALU_WIDTH-1:0] out_result,
	output logic                  flag_n,
	output logic                  flag_z,
	output logic                  flag_v
);

	// Dispatcher to lanes
	logic [`ALU_LANES-1:0]                 issue;
	alu_op_e                               iss_op;
	logic [`ALU_WIDTH-1:0]                 iss_a;
	logic [`ALU_WIDTH-1:0]                 iss_b;

	// Lanes to collector
	logic [`ALU_LANES-1:0]                 lane_done;
	logic [`ALU_LANES-1:0][`ALU_WIDTH-1:0] lane_res;
	logic [`ALU_LANES-1:0]                 lane_n;
	logic [`ALU_LANES-1:0]                 lane_z;
	logic [`ALU_LANES-1:0]                 lane_v;
	logic [`ALU_LANES-1:0]                 lane_we;

	alu_dispatch u_dispatch (
		.clk      (clk),
		.arst_n   (arst_n),
		.in_valid (in_valid),
		.in_op    (in_op),
		.in_a     (in_a),
		.in_b     (in_b),
		.issue    (issue),
		.iss_op   (iss_op),
		.iss_a    (iss_a),
		.iss_b    (iss_b)
	);

	////////////////////
	// Lanes
	////////////////////

	for (genvar i = 0; i < `ALU_LANES; i++) begin : g_lane
		alu_lane u_lane (
			.clk     (clk),
			.arst_n  (arst_n),
			.issue   (issue[i]),
			.iss_op  (iss_op),
			.iss_a   (iss_a),
			.iss_b   (iss_b),
			.done    (lane_done[i]),
			.res     (lane_res[i]),
			.n       (lane_n[i]),
			.z       (lane_z[i]),
			.v       (lane_v[i]),
			.flag_we (lane_we[i])
		);
	end

	alu_collect u_collect (
		.clk        (clk),
		.arst_n     (arst_n),
		.done       (lane_done),
		.res        (lane_res),
		.n          (lane_n),
		.z          (lane_z),
		.v          (lane_v),
		.flag_we    (lane_we),
		.out_valid  (out_valid),
		.out_result (out_result),
		.flag_n     (flag_n),
		.flag_z     (flag_z),
		.flag_v     (flag_v)
	);

endmodule

`default_nettype wire

/* alu_lane.sv */
`default_nettype none

`include "alu_settings.svh"

module alu_lane import alu_pkg::*; (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  issue,
	input  alu_op_e               iss_op,
	input  logic [`ALU_WIDTH-1:0] iss_a,
	input  logic [`ALU_WIDTH-1:0] iss_b,
	output logic                  done,
	output logic [`ALU_WIDTH-1:0] res,
	output logic                  n,
	output logic                  z,
	output logic                  v,
	output logic                  flag_we
);

	localparam int IDX_W = $clog2(`ALU_BYTES);
	localparam int SHW   = $clog2(`ALU_WIDTH);

	lane_state_e           state;
	logic [IDX_W-1:0]      cnt;
	logic                  take;
	alu_op_e               op_q;
	alu_op_e               cur_op;
	logic [`ALU_WIDTH-1:0] a_q;
	logic [`ALU_WIDTH-1:0] b_q;
	logic [`ALU_WIDTH-1:0] cur_a;
	logic [`ALU_WIDTH-1:0] cur_b;
	logic [`ALU_WIDTH-1:0] shift_full;
	logic [`ALU_WIDTH-1:0] acc;
	logic [IDX_W-1:0]      idx;
	logic                  carry_q;
	logic                  carry_in;
	logic                  arith;
	logic                  v_q;
	logic [7:0]            a_byte;
	logic [7:0]            b_byte;
	logic [7:0]            b_add;
	logic [7:0]            byte_res;
	logic [8:0]            sum9;
	logic [7:0]            sum_lo;

	// Lane is free while IDLE or while handing off its result
	assign take = issue && (state != RUN);

	////////////////////
	// Byte slice
	////////////////////

	// Byte 0 is worked straight off the shared buses in the issue cycle
	// Later bytes come from the captured operands
	assign cur_op   = take ? iss_op : op_q;
	assign cur_a    = take ? iss_a : a_q;
	assign cur_b    = take ? iss_b : b_q;
	assign idx      = take ? '0 : cnt;
	// SUB starts with carry in set for the two's complement of b
	assign carry_in = take ? (iss_op == SUB) : carry_q;

	assign arith  = cur_op inside {ADD, ADDI, SUB};
	assign a_byte = cur_a[idx*8 +: 8];
	assign b_byte = cur_b[idx*8 +: 8];
	assign b_add  = (cur_op == SUB) ? ~b_byte : b_byte;

	// Full byte sum plus the low seven bits for the carry into the sign bit
	assign sum9   = {1'b0, a_byte} + {1'b0, b_add} + {8'b0, carry_in};
	assign sum_lo = {1'b0, a_byte[6:0]} + {1'b0, b_add[6:0]} + {7'b0, carry_in};

	// Shifts are done whole and the lane just walks out the bytes
	always_comb begin
		case (cur_op)
			SLL: shift_full = cur_a << cur_b[SHW-1:0];
			SRL: shift_full = cur_a >> cur_b[SHW-1:0];
			default: shift_full = '0;
		endcase
	end

	always_comb begin
		case (cur_op)
			ADD, ADDI, SUB: byte_res = sum9[7:0];
			AND, ANDI: byte_res = a_byte & b_byte;
			NAND: byte_res = ~(a_byte & b_byte);
			XOR: byte_res = a_byte ^ b_byte;
			SLL, SRL: byte_res = shift_full[idx*8 +: 8];
			default: byte_res = '0;
		endcase
	end

	////////////////////
	// Sequencing
	////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (take) begin
						state <= RUN;
						cnt   <= IDX_W'(1);
					end
				end
				RUN: begin
					cnt <= cnt + 1'b1;
					// Top byte this cycle
					if (cnt == IDX_W'(`ALU_BYTES - 1))
						state <= DONE;
				end
				DONE: begin
					// Back-to-back reuse of the lane
					if (take) begin
						state <= RUN;
						cnt   <= IDX_W'(1);
					end else begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Operand capture and result accumulation
	always_ff @(posedge clk) begin
		if (take) begin
			op_q <= iss_op;
			a_q  <= iss_a;
			b_q  <= iss_b;
		end
		if (take || state == RUN) begin
			acc[idx*8 +: 8] <= byte_res;
			carry_q         <= sum9[8];
			// Overflow is carry into bit 31 against carry out of bit 31
			if (idx == IDX_W'(`ALU_BYTES - 1))
				v_q <= arith & (sum_lo[7] ^ sum9[8]);
		end
	end

	assign done    = (state == DONE);
	assign res     = acc;
	assign n       = acc[`ALU_WIDTH-1];
	assign z       = (acc == '0);
	assign v       = v_q;
	// Shifts keep the held flags
	assign flag_we = !(op_q inside {SLL, SRL});

	////////////////////
	// Checks
	////////////////////

	// Dispatcher spacing keeps a busy lane untouched
	a_issue_free: assert property (@(posedge clk) disable iff (!arst_n)
		issue |-> state != RUN);

endmodule

`default_nettype wire

/* alu_pkg.sv */
`default_nettype none

package alu_pkg;

	////////////////////
	// Opcodes
	////////////////////

	// Function codes as seen by the execute stage
	// Immediate forms arrive already extended
	typedef enum logic [5:0] {
		ADD   = 6'h20,
		ADDI  = 6'h21,
		SUB   = 6'h22,
		NAND  = 6'h23,
		AND   = 6'h24,
		ANDI  = 6'h25,
		SRL   = 6'h26,
		SLL   = 6'h27,
		XOR   = 6'h28,
		NO_OP = 6'h3F
	} alu_op_e;

	////////////////////
	// Lane sequencing
	////////////////////

	// Byte-serial lane FSM
	typedef enum logic [1:0] {
		IDLE = 2'd0,
		RUN  = 2'd1,
		DONE = 2'd2
	} lane_state_e;

endpackage

`default_nettype wire

/* alu_settings.svh */
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

////////////////////
// Datapath sizing
////////////////////

// Operand and result width
`define ALU_WIDTH 32

// Number of byte-serial lanes, keep at or above ALU_BYTES for one op per clock
`define ALU_LANES 4

// Bytes per operand, also the lane busy time in cycles
`define ALU_BYTES (`ALU_WIDTH / 8)

`endif

/* alu_trace.txt */
# op a b expect_valid result n z v, all hex
# n z v are the held flags after the line, result is 0 where nothing is expected
20 00000005 00000003 1 00000008 0 0 0
20 7fffffff 00000001 1 80000000 1 0 1
22 80000000 00000001 1 7fffffff 0 0 1
21 ffffffff 00000001 1 00000000 0 1 0
22 00000005 00000005 1 00000000 0 1 0
22 00000003 00000005 1 fffffffe 1 0 0
27 00000001 00000004 1 00000010 1 0 0
24 f0f0f0f0 0ff00ff0 1 00f000f0 0 0 0
25 0000ffff ffff0000 1 00000000 0 1 0
23 ffffffff 0000ffff 1 ffff0000 1 0 0
28 12345678 12345678 1 00000000 0 1 0
3f 00000001 00000001 0 00000000 0 1 0
15 00000001 00000001 0 00000000 0 1 0
26 80000000 0000001f 1 00000001 0 1 0
28 a5a5a5a5 ffffffff 1 5a5a5a5a 0 0 0
20 80000000 80000000 1 00000000 0 1 1
27 12345678 00000024 1 23456780 0 1 1
22 7fffffff ffffffff 1 80000000 1 0 1
26 ffffffff 00000008 1 00ffffff 1 0 1
20 00000001 00000002 1 00000003 0 0 0

/* filelist.f */
+incdir+.
alu_pkg.sv
alu_dispatch.sv
alu_lane.sv
alu_collect.sv
alu_exec.sv
tb_alu_exec.sv

/* tb_alu_exec.sv */
`default_nettype none

`include "alu_settings.svh"

module tb_alu_exec import alu_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD = 20;
	localparam int RESET_CYCLES = 10;
	localparam int TAIL_CYCLES = 8;

	logic                  clk;
	logic                  arst_n;
	logic                  in_valid;
	alu_op_e               in_op;
	logic [`ALU_WIDTH-1:0] in_a;
	logic [`ALU_WIDTH-1:0] in_b;
	logic                  out_valid;
	logic [`ALU_WIDTH-1:0] out_result;
	logic                  flag_n;
	logic                  flag_z;
	logic                  flag_v;

	// Trace contents, one entry per instruction line
	logic [5:0]            op_list[$];
	logic [`ALU_WIDTH-1:0] a_list[$];
	logic [`ALU_WIDTH-1:0] b_list[$];
	logic                  ev_list[$];
	logic [`ALU_WIDTH-1:0] res_list[$];
	logic [2:0]            nzv_list[$];

	// Outstanding results, oldest first
	logic [`ALU_WIDTH-1:0] exp_res_q[$];
	logic [2:0]            exp_nzv_q[$];
	string                 name_q[$];

	int                    n_lines;
	bit                    loaded;

	alu_exec u_dut (
		.clk        (clk),
		.arst_n     (arst_n),
		.in_valid   (in_valid),
		.in_op      (in_op),
		.in_a       (in_a),
		.in_b       (in_b),
		.out_valid  (out_valid),
		.out_result (out_result),
		.flag_n     (flag_n),
		.flag_z     (flag_z),
		.flag_v     (flag_v)
	);

	always #HALF_PERIOD clk = ~clk;

	//////////////////////
	// Compare tasks
	//////////////////////

	task automatic check_result(input string name, input logic [`ALU_WIDTH-1:0] exp,
			input logic [`ALU_WIDTH-1:0] act);
		if (exp !== act) begin
			$display("Fail %s result expected %h actual %h", name, exp, act);
			$display("Test failures found");
			$fatal(1, "result mismatch");
		end
	endtask

	// NZV packed MSB first
	task automatic check_flags(input string name, input logic [2:0] exp,
			input logic [2:0] act);
		if (exp !== act) begin
			$display("Fail %s flags expected %b actual %b", name, exp, act);
			$display("Test failures found");
			$fatal(1, "flag mismatch");
		end
	endtask

	//////////////////////
	// Trace loading
	//////////////////////

	task automatic load_trace();
		int                    fd;
		int                    cnt;
		string                 line;
		logic [5:0]            op;
		logic [`ALU_WIDTH-1:0] a;
		logic [`ALU_WIDTH-1:0] b;
		logic                  ev;
		logic [`ALU_WIDTH-1:0] res;
		logic                  n;
		logic                  z;
		logic                  v;
		fd = $fopen("alu_trace.txt", "r");
		if (fd == 0) begin
			$display("Error: cannot open alu_trace.txt");
			$display("Test failures found");
			$fatal(1, "trace file missing");
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			// Skip comment and blank lines
			if (line.len() > 0 && line[0] != 8'h23) begin
				cnt = $sscanf(line, "%h %h %h %h %h %h %h %h", op, a, b, ev, res, n, z, v);
				if (cnt == 8) begin
					op_list.push_back(op);
					a_list.push_back(a);
					b_list.push_back(b);
					ev_list.push_back(ev);
					res_list.push_back(res);
					nzv_list.push_back({n, z, v});
				end
			end
		end
		$fclose(fd);
		n_lines = op_list.size();
	endtask

	//////////////////////
	// Output monitor
	//////////////////////

	// Falling edge, well clear of the DUT's registered outputs
	always @(negedge clk) begin
		if (arst_n && out_valid) begin
			if (exp_res_q.size() == 0) begin
				$display("Error: out_valid seen with no instruction outstanding");
				$display("Test failures found");
				$fatal(1, "unexpected output");
			end else begin
				check_result(name_q[0], exp_res_q[0], out_result);
				check_flags(name_q[0], exp_nzv_q[0], {flag_n, flag_z, flag_v});
				void'(exp_res_q.pop_front());
				void'(exp_nzv_q.pop_front());
				void'(name_q.pop_front());
			end
		end
	end

	//////////////////////
	// Watchdog
	//////////////////////

	// Worst case three cycles per line plus pipeline drain
	initial begin
		wait (loaded && arst_n);
		repeat (n_lines * 3 + 20) @(posedge clk);
		$display("Error: timeout with %0d results still outstanding", exp_res_q.size());
		$display("Test failures found");
		$fatal(1, "watchdog expired");
	end

	//////////////////////
	// Stimulus
	//////////////////////

	initial begin
		alu_op_e cur_op;
		int      gap;
		clk      = 1'b0;
		arst_n   = 1'b0;
		in_valid = 1'b0;
		in_op    = NO_OP;
		in_a     = '0;
		in_b     = '0;
		loaded   = 1'b0;
		void'($urandom(16225));
		load_trace();
		loaded = 1'b1;

		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;

		for (int i = 0; i < n_lines; i++) begin
			@(posedge clk);
			cur_op = alu_op_e'(op_list[i]);
			in_valid <= 1'b1;
			in_op    <= cur_op;
			in_a     <= a_list[i];
			in_b     <= b_list[i];
			// Only accepted ops are expected at the output
			if (ev_list[i]) begin
				exp_res_q.push_back(res_list[i]);
				exp_nzv_q.push_back(nzv_list[i]);
				name_q.push_back($sformatf("%s line %0d", cur_op.name(), i + 1));
			end
			// Zero to two idle cycles
			gap = int'($urandom % 3);
			repeat (gap) begin
				@(posedge clk);
				in_valid <= 1'b0;
			end
		end
		@(posedge clk);
		in_valid <= 1'b0;

		while (exp_res_q.size() != 0)
			@(posedge clk);
		// Catch any stray output from dropped ops
		repeat (TAIL_CYCLES) @(posedge clk);
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire
